// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module interleaved_ram_tb -f sources.f

output=$(./obj_dir/Vinterleaved_ram_tb || true)
echo "$output"

if echo "$output" | grep -qx "Everything OK"
then
  exit 0
fi
exit 1

// File: sources.f
+incdir+tests
src/mem_pkg.sv
src/bank_ram.sv
src/byte_merge_unit.sv
src/lane_router.sv
src/interleaved_ram.sv
tests/interleaved_ram_tb.sv

// File: src/bank_ram.sv
module bank_ram #(
  parameter int  BANK_DEPTH = 512,
  localparam int ROW_W      = $clog2(BANK_DEPTH)
) (
  input  logic             clk_i,

  input  logic             a_we_i,
  input  logic [ROW_W-1:0] a_row_i,
  input  mem_pkg::word_t   a_wdata_i,
  output mem_pkg::word_t   a_rdata_o,

  input  logic             b_we_i,
  input  logic [ROW_W-1:0] b_row_i,
  input  mem_pkg::word_t   b_wdata_i,
  output mem_pkg::word_t   b_rdata_o
);

  import mem_pkg::*;

  word_t mem [BANK_DEPTH];

  // Both ports in one process; a read returns the word held before the edge.
  always_ff @(posedge clk_i)
  begin
    if (a_we_i)
    begin
      mem[a_row_i] <= a_wdata_i;
    end
    if (b_we_i)
    begin
      mem[b_row_i] <= b_wdata_i;
    end
    a_rdata_o <= mem[a_row_i];
    b_rdata_o <= mem[b_row_i];
  end

endmodule

// File: src/byte_merge_unit.sv
module byte_merge_unit #(
  parameter int  BANK_DEPTH = 512,
  localparam int ROW_W      = $clog2(BANK_DEPTH)
) (
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             acc_i,
  input  logic             acc_we_i,
  input  mem_pkg::addr_t   acc_addr_i,
  input  mem_pkg::be_t     acc_be_i,
  input  mem_pkg::word_t   acc_wdata_i,

  output logic             busy_o,
  output logic             resp_o,
  output mem_pkg::word_t   rdata_o,

  output logic             ram_we_o,
  output logic [ROW_W-1:0] ram_row_o,
  output mem_pkg::word_t   ram_wdata_o,
  input  mem_pkg::word_t   ram_rdata_i
);

  import mem_pkg::*;

  logic             full_wr;
  logic             part_wr;
  logic             rd;

  logic             pend_q;
  logic             resp_q;

  logic [ROW_W-1:0] row_q;
  ofs_t             ofs_q;
  be_t              be_q;
  word_t            wdata_q;
  ofs_t             rd_ofs_q;

  be_t              shift_be;
  word_t            shift_data;
  word_t            merge_data;

  assign full_wr = acc_i & acc_we_i & (acc_be_i == '1);
  assign part_wr = acc_i & acc_we_i & (acc_be_i != '1);
  assign rd      = acc_i & ~acc_we_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pend_q <= 1'b0;
      resp_q <= 1'b0;
    end
    else
    begin
      pend_q <= part_wr;  // Write back in the next cycle.
      resp_q <= rd;
    end
  end

  // Sub-word write buffer and read offset.
  always_ff @(posedge clk_i)
  begin
    if (part_wr)
    begin
      row_q   <= acc_addr_i[ROW_LSB +: ROW_W];
      ofs_q   <= acc_addr_i[OFS_W-1:0];
      be_q    <= acc_be_i;
      wdata_q <= acc_wdata_i;
    end
    if (rd)
    begin
      rd_ofs_q <= acc_addr_i[OFS_W-1:0];
    end
  end

  // Bytes move up by the offset, the top ones fall off.
  assign shift_be   = be_q << ofs_q;
  assign shift_data = wdata_q << {ofs_q, 3'b000};

  always_comb
  begin
    merge_data = ram_rdata_i;  // Old word, read in the accept cycle.
    for (int i = 0; i < BYTES_W; i++)
    begin
      if (shift_be[i])
      begin
        merge_data[8*i +: 8] = shift_data[8*i +: 8];
      end
    end
  end

  assign ram_we_o    = pend_q | full_wr;
  assign ram_row_o   = pend_q ? row_q : acc_addr_i[ROW_LSB +: ROW_W];
  assign ram_wdata_o = pend_q ? merge_data : acc_wdata_i;

  assign busy_o  = pend_q;
  assign resp_o  = resp_q;
  assign rdata_o = ram_rdata_i >> {rd_ofs_q, 3'b000};  // Zero fill at the top.

endmodule

// File: src/interleaved_ram.sv
module interleaved_ram #(
  parameter int BANK_DEPTH = 512
) (
  input  logic           clk_i,
  input  logic           arst_n_i,

  input  logic           p0_l0_req_i,
  input  logic           p0_l0_we_i,
  input  mem_pkg::addr_t p0_l0_addr_i,
  input  mem_pkg::be_t   p0_l0_be_i,
  input  mem_pkg::word_t p0_l0_wdata_i,
  output logic           p0_l0_ack_o,
  output logic           p0_l0_resp_o,
  output mem_pkg::word_t p0_l0_rdata_o,

  input  logic           p0_l1_req_i,
  input  logic           p0_l1_we_i,
  input  mem_pkg::addr_t p0_l1_addr_i,
  input  mem_pkg::be_t   p0_l1_be_i,
  input  mem_pkg::word_t p0_l1_wdata_i,
  output logic           p0_l1_ack_o,
  output logic           p0_l1_resp_o,
  output mem_pkg::word_t p0_l1_rdata_o,

  input  logic           p1_l0_req_i,
  input  logic           p1_l0_we_i,
  input  mem_pkg::addr_t p1_l0_addr_i,
  input  mem_pkg::be_t   p1_l0_be_i,
  input  mem_pkg::word_t p1_l0_wdata_i,
  output logic           p1_l0_ack_o,
  output logic           p1_l0_resp_o,
  output mem_pkg::word_t p1_l0_rdata_o,

  input  logic           p1_l1_req_i,
  input  logic           p1_l1_we_i,
  input  mem_pkg::addr_t p1_l1_addr_i,
  input  mem_pkg::be_t   p1_l1_be_i,
  input  mem_pkg::word_t p1_l1_wdata_i,
  output logic           p1_l1_ack_o,
  output logic           p1_l1_resp_o,
  output mem_pkg::word_t p1_l1_rdata_o
);

  import mem_pkg::*;

  localparam int ROW_W = $clog2(BANK_DEPTH);

  // Indexed [bus port][bank].
  logic             acc       [2][2];
  logic             acc_we    [2][2];
  addr_t            acc_addr  [2][2];
  be_t              acc_be    [2][2];
  word_t            acc_wdata [2][2];
  logic             busy      [2][2];
  logic             resp      [2][2];
  word_t            rdata     [2][2];

  logic             ram_we    [2][2];
  logic [ROW_W-1:0] ram_row   [2][2];
  word_t            ram_wdata [2][2];
  word_t            ram_rdata [2][2];

  lane_router u_router_p0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .l0_req_i(p0_l0_req_i), .l0_we_i(p0_l0_we_i), .l0_addr_i(p0_l0_addr_i),
    .l0_be_i(p0_l0_be_i), .l0_wdata_i(p0_l0_wdata_i),
    .l0_ack_o(p0_l0_ack_o), .l0_resp_o(p0_l0_resp_o), .l0_rdata_o(p0_l0_rdata_o),
    .l1_req_i(p0_l1_req_i), .l1_we_i(p0_l1_we_i), .l1_addr_i(p0_l1_addr_i),
    .l1_be_i(p0_l1_be_i), .l1_wdata_i(p0_l1_wdata_i),
    .l1_ack_o(p0_l1_ack_o), .l1_resp_o(p0_l1_resp_o), .l1_rdata_o(p0_l1_rdata_o),
    .b0_acc_o(acc[0][0]), .b0_we_o(acc_we[0][0]), .b0_addr_o(acc_addr[0][0]),
    .b0_be_o(acc_be[0][0]), .b0_wdata_o(acc_wdata[0][0]),
    .b0_busy_i(busy[0][0]), .b0_resp_i(resp[0][0]), .b0_rdata_i(rdata[0][0]),
    .b1_acc_o(acc[0][1]), .b1_we_o(acc_we[0][1]), .b1_addr_o(acc_addr[0][1]),
    .b1_be_o(acc_be[0][1]), .b1_wdata_o(acc_wdata[0][1]),
    .b1_busy_i(busy[0][1]), .b1_resp_i(resp[0][1]), .b1_rdata_i(rdata[0][1])
  );

  lane_router u_router_p1 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .l0_req_i(p1_l0_req_i), .l0_we_i(p1_l0_we_i), .l0_addr_i(p1_l0_addr_i),
    .l0_be_i(p1_l0_be_i), .l0_wdata_i(p1_l0_wdata_i),
    .l0_ack_o(p1_l0_ack_o), .l0_resp_o(p1_l0_resp_o), .l0_rdata_o(p1_l0_rdata_o),
    .l1_req_i(p1_l1_req_i), .l1_we_i(p1_l1_we_i), .l1_addr_i(p1_l1_addr_i),
    .l1_be_i(p1_l1_be_i), .l1_wdata_i(p1_l1_wdata_i),
    .l1_ack_o(p1_l1_ack_o), .l1_resp_o(p1_l1_resp_o), .l1_rdata_o(p1_l1_rdata_o),
    .b0_acc_o(acc[1][0]), .b0_we_o(acc_we[1][0]), .b0_addr_o(acc_addr[1][0]),
    .b0_be_o(acc_be[1][0]), .b0_wdata_o(acc_wdata[1][0]),
    .b0_busy_i(busy[1][0]), .b0_resp_i(resp[1][0]), .b0_rdata_i(rdata[1][0]),
    .b1_acc_o(acc[1][1]), .b1_we_o(acc_we[1][1]), .b1_addr_o(acc_addr[1][1]),
    .b1_be_o(acc_be[1][1]), .b1_wdata_o(acc_wdata[1][1]),
    .b1_busy_i(busy[1][1]), .b1_resp_i(resp[1][1]), .b1_rdata_i(rdata[1][1])
  );

  // One merge unit per bus port and bank.
  for (genvar p = 0; p < 2; p++)
  begin : g_port
    for (genvar b = 0; b < 2; b++)
    begin : g_bank
      byte_merge_unit #(
        .BANK_DEPTH(BANK_DEPTH)
      ) u_merge (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .acc_i(acc[p][b]), .acc_we_i(acc_we[p][b]), .acc_addr_i(acc_addr[p][b]),
        .acc_be_i(acc_be[p][b]), .acc_wdata_i(acc_wdata[p][b]),
        .busy_o(busy[p][b]), .resp_o(resp[p][b]), .rdata_o(rdata[p][b]),
        .ram_we_o(ram_we[p][b]), .ram_row_o(ram_row[p][b]),
        .ram_wdata_o(ram_wdata[p][b]), .ram_rdata_i(ram_rdata[p][b])
      );
    end
  end

  // RAM port a belongs to bus port 0, port b to bus port 1.
  for (genvar b = 0; b < 2; b++)
  begin : g_ram
    bank_ram #(
      .BANK_DEPTH(BANK_DEPTH)
    ) u_ram (
      .clk_i(clk_i),
      .a_we_i(ram_we[0][b]), .a_row_i(ram_row[0][b]),
      .a_wdata_i(ram_wdata[0][b]), .a_rdata_o(ram_rdata[0][b]),
      .b_we_i(ram_we[1][b]), .b_row_i(ram_row[1][b]),
      .b_wdata_i(ram_wdata[1][b]), .b_rdata_o(ram_rdata[1][b])
    );
  end

endmodule

// File: src/lane_router.sv
module lane_router (
  input  logic           clk_i,
  input  logic           arst_n_i,

  input  logic           l0_req_i,
  input  logic           l0_we_i,
  input  mem_pkg::addr_t l0_addr_i,
  input  mem_pkg::be_t   l0_be_i,
  input  mem_pkg::word_t l0_wdata_i,
  output logic           l0_ack_o,
  output logic           l0_resp_o,
  output mem_pkg::word_t l0_rdata_o,

  input  logic           l1_req_i,
  input  logic           l1_we_i,
  input  mem_pkg::addr_t l1_addr_i,
  input  mem_pkg::be_t   l1_be_i,
  input  mem_pkg::word_t l1_wdata_i,
  output logic           l1_ack_o,
  output logic           l1_resp_o,
  output mem_pkg::word_t l1_rdata_o,

  output logic           b0_acc_o,
  output logic           b0_we_o,
  output mem_pkg::addr_t b0_addr_o,
  output mem_pkg::be_t   b0_be_o,
  output mem_pkg::word_t b0_wdata_o,
  input  logic           b0_busy_i,
  input  logic           b0_resp_i,
  input  mem_pkg::word_t b0_rdata_i,

  output logic           b1_acc_o,
  output logic           b1_we_o,
  output mem_pkg::addr_t b1_addr_o,
  output mem_pkg::be_t   b1_be_o,
  output mem_pkg::word_t b1_wdata_o,
  input  logic           b1_busy_i,
  input  logic           b1_resp_i,
  input  mem_pkg::word_t b1_rdata_i
);

  import mem_pkg::*;

  logic l0_bank;
  logic l1_bank;
  logic l0_busy;
  logic l1_busy;
  logic swap;
  logic swap_q;

  assign l0_bank = l0_addr_i[BANK_BIT];
  assign l1_bank = l1_addr_i[BANK_BIT];

  // Set when bank 0 serves lane 1 and bank 1 serves lane 0.
  assign swap = l0_req_i ? l0_bank : ~l1_bank;

  assign l0_busy = l0_bank ? b1_busy_i : b0_busy_i;
  assign l1_busy = l1_bank ? b1_busy_i : b0_busy_i;

  // Lane 0 wins a shared bank.
  assign l0_ack_o = l0_req_i & ~l0_busy;
  assign l1_ack_o = l1_req_i & ~l1_busy & ~(l0_req_i & (l1_bank == l0_bank));

  assign b0_acc_o   = swap ? l1_ack_o   : l0_ack_o;
  assign b0_we_o    = swap ? l1_we_i    : l0_we_i;
  assign b0_addr_o  = swap ? l1_addr_i  : l0_addr_i;
  assign b0_be_o    = swap ? l1_be_i    : l0_be_i;
  assign b0_wdata_o = swap ? l1_wdata_i : l0_wdata_i;

  assign b1_acc_o   = swap ? l0_ack_o   : l1_ack_o;
  assign b1_we_o    = swap ? l0_we_i    : l1_we_i;
  assign b1_addr_o  = swap ? l0_addr_i  : l1_addr_i;
  assign b1_be_o    = swap ? l0_be_i    : l1_be_i;
  assign b1_wdata_o = swap ? l0_wdata_i : l1_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      swap_q <= 1'b0;
    end
    else
    begin
      swap_q <= swap;
    end
  end

  // Responses come one cycle after the accept.
  assign l0_resp_o  = swap_q ? b1_resp_i  : b0_resp_i;
  assign l0_rdata_o = swap_q ? b1_rdata_i : b0_rdata_i;
  assign l1_resp_o  = swap_q ? b0_resp_i  : b1_resp_i;
  assign l1_rdata_o = swap_q ? b0_rdata_i : b1_rdata_i;

endmodule

// File: src/mem_pkg.sv
package mem_pkg;

  // Bus and word geometry.
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int BYTES_W = 4;
  localparam int OFS_W   = 2;

  // Consecutive words alternate between the two banks.
  localparam int BANK_BIT = 2;
  localparam int ROW_LSB  = 3;  // Row index starts above the bank bit.

  // Byte address.
  typedef logic [ADDR_W-1:0] addr_t;

  // Data word.
  typedef logic [DATA_W-1:0] word_t;

  // One enable per byte lane.
  typedef logic [BYTES_W-1:0] be_t;

  // Byte offset inside a word.
  typedef logic [OFS_W-1:0] ofs_t;

endpackage

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Lane k is bus port k/2, lane k%2, and bit k of req, we and ack.
// addr packs four 12-bit byte addresses, be four nibbles, wdata four words; lane 3 first.
typedef struct {
  string          name;
  bit             rnd;    // Write data taken from $urandom.
  bit             retry;  // Refused lanes hold until acknowledged.
  int             acks;   // Cycle of the last ack, retry rows only.
  bit [3:0]       req;
  bit [3:0]       we;
  bit [3:0]       ack;    // Expected in the first cycle.
  bit [3:0][11:0] addr;
  bit [3:0][3:0]  be;
  bit [3:0][31:0] wdata;
} vec_t;

localparam int NUM_VECS = 23;

vec_t vectors [NUM_VECS] = '{
  '{"wr 100/104", 1'b1, 1'b0, 0, 4'b0011, 4'b0011, 4'b0011, 48'h000_000_104_100, 16'h00FF, '0},
  '{"wr 108/10C", 1'b1, 1'b0, 0, 4'b0011, 4'b0011, 4'b0011, 48'h000_000_10C_108, 16'h00FF, '0},
  '{"wr 110/114", 1'b1, 1'b0, 0, 4'b0011, 4'b0011, 4'b0011, 48'h000_000_114_110, 16'h00FF, '0},
  '{"wr 118/11C", 1'b1, 1'b0, 0, 4'b0011, 4'b0011, 4'b0011, 48'h000_000_11C_118, 16'h00FF, '0},
  '{"rd 100 110", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h114_110_104_100, 16'h0000, '0},
  '{"rd 108 118", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h11C_118_10C_108, 16'h0000, '0},
  '{"rd 110 100", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h104_100_114_110, 16'h0000, '0},
  '{"rd 118 108", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h10C_108_11C_118, 16'h0000, '0},
  '{"lane swap", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h110_11C_108_104, 16'h0000, '0},
  '{"lane1 only", 1'b0, 1'b0, 0, 4'b1010, 4'b0000, 4'b1010, 48'h100_000_10C_000, 16'h0000, '0},
  '{"conflict", 1'b0, 1'b1, 2, 4'b1111, 4'b0000, 4'b0101, 48'h104_10C_118_100, 16'h0000, '0},
  '{"known 200", 1'b0, 1'b0, 0, 4'b0011, 4'b0011, 4'b0011, 48'h000_000_20C_200, 16'h00FF,
    128'h00000000_00000000_55667788_11223344},
  '{"known 210", 1'b0, 1'b0, 0, 4'b0011, 4'b0011, 4'b0011, 48'h000_000_21C_210, 16'h00FF,
    128'h00000000_00000000_01020304_99AABBCC},
  '{"sub ofs 0", 1'b0, 1'b0, 0, 4'b0001, 4'b0001, 4'b0001, 48'h000_000_000_200, 16'h0001,
    128'h00000000_00000000_00000000_000000AA},
  '{"busy p0 b0", 1'b0, 1'b1, 2, 4'b0011, 4'b0000, 4'b0010, 48'h000_000_20C_200, 16'h0000, '0},
  '{"sub ofs 1", 1'b0, 1'b0, 0, 4'b0100, 4'b0100, 4'b0100, 48'h000_20D_000_000, 16'h0300,
    128'h00000000_0000BBCC_00000000_00000000},
  '{"busy p1 b1", 1'b0, 1'b1, 2, 4'b1100, 4'b0000, 4'b1000, 48'h200_20C_000_000, 16'h0000, '0},
  '{"sub ofs 2", 1'b0, 1'b0, 0, 4'b0010, 4'b0010, 4'b0010, 48'h000_000_212_000, 16'h0050,
    128'h00000000_00000000_00DD00EE_00000000},
  '{"busy p0 #2", 1'b0, 1'b1, 2, 4'b0010, 4'b0000, 4'b0000, 48'h000_000_210_000, 16'h0000, '0},
  '{"sub ofs 3", 1'b0, 1'b0, 0, 4'b1000, 4'b1000, 4'b1000, 48'h21F_000_000_000, 16'h9000,
    128'hAB0000FF_00000000_00000000_00000000},
  '{"busy p1 #2", 1'b0, 1'b1, 2, 4'b1000, 4'b0000, 4'b0000, 48'h21C_000_000_000, 16'h0000, '0},
  '{"read back", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h21C_210_20C_200, 16'h0000, '0},
  '{"ofs reads", 1'b0, 1'b0, 0, 4'b1111, 4'b0000, 4'b1111, 48'h21D_213_20E_201, 16'h0000, '0}
};

`endif

// File: tests/interleaved_ram_tb.sv
module interleaved_ram_tb;

  import mem_pkg::*;

  localparam int BANK_DEPTH = 512;

  logic       clk_i;
  logic       arst_n_i;
  logic [3:0] req;
  logic [3:0] we;
  addr_t      addr  [4];
  be_t        be    [4];
  word_t      wdata [4];
  logic [3:0] ack;
  logic [3:0] resp;
  word_t      rdata [4];

  word_t      model [int];  // Expected content by word address.
  logic [3:0] rd_pend;      // Reads accepted in the last cycle.
  word_t      rd_exp [4];
  string      rd_name;

  `include "tb_vectors.svh"

  interleaved_ram #(
    .BANK_DEPTH(BANK_DEPTH)
  ) UUT (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .p0_l0_req_i(req[0]), .p0_l0_we_i(we[0]), .p0_l0_addr_i(addr[0]),
    .p0_l0_be_i(be[0]), .p0_l0_wdata_i(wdata[0]),
    .p0_l0_ack_o(ack[0]), .p0_l0_resp_o(resp[0]), .p0_l0_rdata_o(rdata[0]),
    .p0_l1_req_i(req[1]), .p0_l1_we_i(we[1]), .p0_l1_addr_i(addr[1]),
    .p0_l1_be_i(be[1]), .p0_l1_wdata_i(wdata[1]),
    .p0_l1_ack_o(ack[1]), .p0_l1_resp_o(resp[1]), .p0_l1_rdata_o(rdata[1]),
    .p1_l0_req_i(req[2]), .p1_l0_we_i(we[2]), .p1_l0_addr_i(addr[2]),
    .p1_l0_be_i(be[2]), .p1_l0_wdata_i(wdata[2]),
    .p1_l0_ack_o(ack[2]), .p1_l0_resp_o(resp[2]), .p1_l0_rdata_o(rdata[2]),
    .p1_l1_req_i(req[3]), .p1_l1_we_i(we[3]), .p1_l1_addr_i(addr[3]),
    .p1_l1_be_i(be[3]), .p1_l1_wdata_i(wdata[3]),
    .p1_l1_ack_o(ack[3]), .p1_l1_resp_o(resp[3]), .p1_l1_rdata_o(rdata[3])
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic word_t expected_read(addr_t a);
    return model[int'(a >> 2)] >> (8 * a[1:0]);  // Zeros come in at the top.
  endfunction

  // Full words go in as they are; other writes move up by the byte offset.
  task automatic update_model(addr_t a, be_t b, word_t d);
    word_t old;
    be_t   sb;
    word_t sd;
    old = model.exists(int'(a >> 2)) ? model[int'(a >> 2)] : '0;
    sb  = b << a[1:0];
    sd  = d << (8 * a[1:0]);
    for (int i = 0; i < 4; i++)
    begin
      if (sb[i])
      begin
        old[8*i +: 8] = sd[8*i +: 8];
      end
    end
    model[int'(a >> 2)] = (b == 4'hF) ? d : old;
  endtask

  task automatic check_responses();
    for (int k = 0; k < 4; k++)
    begin
      assert (resp[k] == rd_pend[k])
      else
      begin
        $display("** Error %s: lane %0d resp expected %b, actual %b",
                 rd_name, k, rd_pend[k], resp[k]);
        stop_run();
      end
      if (rd_pend[k])
      begin
        assert (rdata[k] == rd_exp[k])
        else
        begin
          $display("** Error %s: lane %0d rdata expected %h, actual %h",
                   rd_name, k, rd_exp[k], rdata[k]);
          stop_run();
        end
      end
    end
    rd_pend = 4'b0000;
  endtask

  task automatic run_vector(int v);
    logic [3:0] pend;
    word_t      wd [4];
    int         cyc;
    int         last_ack;
    pend     = vectors[v].req;
    cyc      = 0;
    last_ack = 0;
    for (int k = 0; k < 4; k++)
    begin
      wd[k] = vectors[v].rnd ? $urandom : vectors[v].wdata[k];
    end
    do
    begin
      @(negedge clk_i);
      check_responses();
      rd_name = vectors[v].name;
      for (int k = 0; k < 4; k++)
      begin
        req[k]   = pend[k];
        we[k]    = vectors[v].we[k];
        addr[k]  = {20'b0, vectors[v].addr[k]};
        be[k]    = vectors[v].be[k];
        wdata[k] = wd[k];
      end
      #1;
      cyc++;
      if (cyc == 1)
      begin
        assert (ack == vectors[v].ack)
        else
        begin
          $display("** Error %s: ack expected %b, actual %b", rd_name, vectors[v].ack, ack);
          stop_run();
        end
      end
      // Reads see the content from before this cycle's writes.
      for (int k = 0; k < 4; k++)
      begin
        if (pend[k] && ack[k])
        begin
          last_ack = cyc;
          if (!we[k])
          begin
            rd_pend[k] = 1'b1;
            rd_exp[k]  = expected_read(addr[k]);
          end
        end
      end
      for (int k = 0; k < 4; k++)
      begin
        if (pend[k] && ack[k] && we[k])
        begin
          update_model(addr[k], be[k], wdata[k]);
        end
      end
      pend = vectors[v].retry ? (pend & ~ack) : 4'b0000;
    end
    while (pend != 4'b0000);
    if (vectors[v].retry)
    begin
      assert (last_ack == vectors[v].acks)
      else
      begin
        $display("** Error %s: last ack cycle expected %0d, actual %0d",
                 rd_name, vectors[v].acks, last_ack);
        stop_run();
      end
    end
  endtask

  initial
  begin
    void'($urandom(79));
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    req      = 4'b0000;
    we       = 4'b0000;
    for (int k = 0; k < 4; k++)
    begin
      addr[k]  = '0;
      be[k]    = '0;
      wdata[k] = '0;
    end
    rd_pend = 4'b0000;
    rd_name = "reset";
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    for (int v = 0; v < NUM_VECS; v++)
    begin
      run_vector(v);
    end
    @(negedge clk_i);
    check_responses();  // Last row's reads.
    $display("Everything OK");
    $finish;
  end

  initial
  begin
    #(NUM_VECS * 10 * 20);
    $display("Timeout: the test sequence did not finish in time");
    stop_run();
  end

endmodule
